// File: common/mem_sys_macros.svh
`ifndef MEM_SYS_MACROS_SVH
`define MEM_SYS_MACROS_SVH

// Bus widths
`define MS_ADDR_W   32
`define MS_DATA_W   32

// Direct mapped geometry, one word per line
`define MS_LINES    16
`define MS_INDEX_W  4
`define MS_OFFSET_W 2   // Byte offset inside a word

// What is left of the address for the tag
`define MS_TAG_W    (`MS_ADDR_W - `MS_INDEX_W - `MS_OFFSET_W)

`endif

// File: common/mem_sys_pkg.sv
`default_nettype none
`include "mem_sys_macros.svh"

package mem_sys_pkg;

   // Byte address as the caches see it
   typedef struct packed {
      logic [`MS_TAG_W-1:0]    tag;
      logic [`MS_INDEX_W-1:0]  index;
      logic [`MS_OFFSET_W-1:0] offset;
   } cache_addr_t;

   typedef struct packed {
      logic        rd;
      cache_addr_t addr;
   } ic_req_t;

   // At most one of rd and wr high
   typedef struct packed {
      logic                  rd;
      logic                  wr;
      cache_addr_t           addr;
      logic [`MS_DATA_W-1:0] wdata;
   } dc_req_t;

   typedef struct packed {
      logic                  hit;   // Low means stall
      logic [`MS_DATA_W-1:0] data;
   } cache_rsp_t;

   // Cache miss or write towards the arbiter, held until ack
   typedef struct packed {
      logic                  req;
      logic                  we;
      logic [`MS_ADDR_W-1:0] addr;
      logic [`MS_DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic                  ack;   // Single cycle pulse
      logic [`MS_DATA_W-1:0] rdata;
   } mem_rsp_t;

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`MS_ADDR_W-1:0] adr;
      logic [`MS_DATA_W-1:0] dat;
   } wb_m2s_t;

   typedef struct packed {
      logic                  ack;
      logic [`MS_DATA_W-1:0] dat;
   } wb_s2m_t;

endpackage

`default_nettype wire

// File: cache/cache_array.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module cache_array
   import mem_sys_pkg::*;
(
   input  logic                  clk,
   input  logic                  mem_wb_reset,
   input  cache_addr_t           lookup_addr,
   input  logic                  fill,
   input  logic                  upd,
   input  logic [`MS_DATA_W-1:0] wdata,
   output logic                  hit,
   output logic [`MS_DATA_W-1:0] rdata
);

   logic [`MS_LINES-1:0]  valid;
   logic [`MS_TAG_W-1:0]  tags  [`MS_LINES];
   logic [`MS_DATA_W-1:0] words [`MS_LINES];

   // Lookup is purely combinational
   assign hit   = valid[lookup_addr.index] && (tags[lookup_addr.index] == lookup_addr.tag);
   assign rdata = words[lookup_addr.index];

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         valid <= '0;
      end else if (fill) begin
         valid[lookup_addr.index] <= 1'b1;
      end
   end

   // Tag and data storage
   always_ff @(posedge clk) begin
      if (fill) begin
         tags[lookup_addr.index]  <= lookup_addr.tag;
         words[lookup_addr.index] <= wdata;
      end else if (upd && hit) begin
         words[lookup_addr.index] <= wdata;   // Write through a line already present
      end
   end

endmodule

`default_nettype wire

// File: cache/icache.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module icache
   import mem_sys_pkg::*;
(
   input  logic       clk,
   input  logic       mem_wb_reset,
   input  ic_req_t    ic_req,
   input  mem_rsp_t   mem_rsp,
   output cache_rsp_t ic_rsp,
   output mem_req_t   mem_req
);

   typedef enum logic {
      st_idle,
      st_refill
   } state_t;

   state_t                state;
   logic                  arr_hit;
   logic [`MS_DATA_W-1:0] arr_rdata;
   logic                  fill;

   cache_array cache_array_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .lookup_addr  (ic_req.addr),
      .fill         (fill),
      .upd          (1'b0),            // Read only
      .wdata        (mem_rsp.rdata),
      .hit          (arr_hit),
      .rdata        (arr_rdata)
   );

   assign fill = (state == st_refill) && mem_rsp.ack;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (ic_req.rd && !arr_hit) begin
                  state <= st_refill;
               end
            end
            st_refill: begin
               if (mem_rsp.ack) begin
                  state <= st_idle;   // Line is written on this edge
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_comb begin
      ic_rsp.hit    = ic_req.rd && arr_hit;
      ic_rsp.data   = arr_rdata;

      // Word aligned read of the missing line
      mem_req.req   = (state == st_refill);
      mem_req.we    = 1'b0;
      mem_req.addr  = {ic_req.addr.tag, ic_req.addr.index, {`MS_OFFSET_W{1'b0}}};
      mem_req.wdata = '0;
   end

endmodule

`default_nettype wire

// File: cache/dcache.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module dcache
   import mem_sys_pkg::*;
(
   input  logic       clk,
   input  logic       mem_wb_reset,
   input  dc_req_t    dc_req,
   input  mem_rsp_t   mem_rsp,
   output cache_rsp_t dc_rsp,
   output mem_req_t   mem_req
);

   typedef enum logic [1:0] {
      st_idle,
      st_refill,
      st_write,
      st_done
   } state_t;

   state_t                state;
   logic                  arr_hit;
   logic [`MS_DATA_W-1:0] arr_rdata;
   logic [`MS_DATA_W-1:0] arr_wdata;
   logic                  fill;
   logic                  upd;

   cache_array cache_array_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .lookup_addr  (dc_req.addr),
      .fill         (fill),
      .upd          (upd),
      .wdata        (arr_wdata),
      .hit          (arr_hit),
      .rdata        (arr_rdata)
   );

   assign fill = (state == st_refill) && mem_rsp.ack;
   assign upd  = (state == st_write) && mem_rsp.ack;   // Array ignores it on a miss

   // Refill data from memory, store data from the requester
   assign arr_wdata = (state == st_write) ? dc_req.wdata : mem_rsp.rdata;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (dc_req.rd && !arr_hit) begin
                  state <= st_refill;
               end else if (dc_req.wr) begin
                  state <= st_write;   // Every store goes to memory
               end
            end
            st_refill: begin
               if (mem_rsp.ack) begin
                  state <= st_idle;
               end
            end
            st_write: begin
               if (mem_rsp.ack) begin
                  state <= st_done;
               end
            end
            st_done: state <= st_idle;   // One cycle of hit for the store
            default: state <= st_idle;
         endcase
      end
   end

   always_comb begin
      dc_rsp.hit    = ((state == st_idle) && dc_req.rd && arr_hit) || (state == st_done);
      dc_rsp.data   = arr_rdata;

      mem_req.req   = (state == st_refill) || (state == st_write);
      mem_req.we    = (state == st_write);
      mem_req.addr  = {dc_req.addr.tag, dc_req.addr.index, {`MS_OFFSET_W{1'b0}}};
      mem_req.wdata = dc_req.wdata;
   end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module mem_arbiter
   import mem_sys_pkg::*;
(
   input  logic     clk,
   input  logic     mem_wb_reset,
   input  mem_req_t ic_mem_req,
   input  mem_req_t dc_mem_req,
   input  wb_s2m_t  wb_i,
   output mem_rsp_t ic_mem_rsp,
   output mem_rsp_t dc_mem_rsp,
   output wb_m2s_t  wb_o
);

   logic                  cyc;        // Also marks the grant as held
   logic                  owner_dc;   // Which cache holds the grant
   logic                  we_q;
   logic [`MS_ADDR_W-1:0] adr_q;
   logic [`MS_DATA_W-1:0] dat_q;
   mem_req_t              sel_req;

   // Data cache wins a tie
   assign sel_req = dc_mem_req.req ? dc_mem_req : ic_mem_req;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         cyc      <= 1'b0;
         owner_dc <= 1'b0;
      end else if (!cyc) begin
         if (sel_req.req) begin
            cyc      <= 1'b1;
            owner_dc <= dc_mem_req.req;
         end
      end else if (wb_i.ack) begin
         cyc <= 1'b0;   // Release, bus rests one cycle
      end
   end

   // Bus fields captured with the grant, fixed until ack
   always_ff @(posedge clk) begin
      if (!cyc) begin
         we_q  <= sel_req.we;
         adr_q <= sel_req.addr;
         dat_q <= sel_req.wdata;
      end
   end

   always_comb begin
      wb_o.cyc = cyc;
      wb_o.stb = cyc;   // Classic cycle, no bursts
      wb_o.we  = we_q;
      wb_o.adr = adr_q;
      wb_o.dat = dat_q;

      // Ack and data go back to the owner only
      dc_mem_rsp.ack   = cyc && owner_dc && wb_i.ack;
      dc_mem_rsp.rdata = owner_dc ? wb_i.dat : '0;
      ic_mem_rsp.ack   = cyc && !owner_dc && wb_i.ack;
      ic_mem_rsp.rdata = owner_dc ? '0 : wb_i.dat;
   end

endmodule

`default_nettype wire

// File: rtl/mem_sys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_sys_top
   import mem_sys_pkg::*;
(
   input  logic       clk,
   input  logic       mem_wb_reset,
   input  ic_req_t    ic_req,
   input  dc_req_t    dc_req,
   input  wb_s2m_t    wb_i,
   output cache_rsp_t ic_rsp,
   output cache_rsp_t dc_rsp,
   output wb_m2s_t    wb_o
);

   // Miss traffic between caches and arbiter
   mem_req_t ic_mem_req;
   mem_req_t dc_mem_req;
   mem_rsp_t ic_mem_rsp;
   mem_rsp_t dc_mem_rsp;

   icache icache_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .ic_req       (ic_req),
      .mem_rsp      (ic_mem_rsp),
      .ic_rsp       (ic_rsp),
      .mem_req      (ic_mem_req)
   );

   dcache dcache_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .dc_req       (dc_req),
      .mem_rsp      (dc_mem_rsp),
      .dc_rsp       (dc_rsp),
      .mem_req      (dc_mem_req)
   );

   // Single external memory bus
   mem_arbiter mem_arbiter_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .ic_mem_req   (ic_mem_req),
      .dc_mem_req   (dc_mem_req),
      .wb_i         (wb_i),
      .ic_mem_rsp   (ic_mem_rsp),
      .dc_mem_rsp   (dc_mem_rsp),
      .wb_o         (wb_o)
   );

endmodule

`default_nettype wire

// File: tests/wb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module wb_mem_model
   import mem_sys_pkg::*;
(
   input  logic    clk,
   input  logic    mem_wb_reset,
   input  wb_m2s_t wb_m,
   output wb_s2m_t wb_s
);

   localparam int LOG_DEPTH = 1024;

   typedef logic [`MS_ADDR_W-1:0] addr_t;

   logic [`MS_DATA_W-1:0] mem [addr_t];   // Sparse, holds written words only
   logic                  busy;
   logic [1:0]            wait_left;

   // Transaction log, one entry per acked cycle
   int                    txn_count = 0;
   addr_t                 txn_adr [LOG_DEPTH];
   logic                  txn_we  [LOG_DEPTH];
   logic [`MS_DATA_W-1:0] txn_dat [LOG_DEPTH];

   function automatic addr_t word_addr(addr_t adr);
      return {adr[`MS_ADDR_W-1:`MS_OFFSET_W], {`MS_OFFSET_W{1'b0}}};
   endfunction

   always @(posedge clk) begin
      if (mem_wb_reset) begin
         wb_s <= '0;
         busy <= 1'b0;
      end else if (wb_s.ack) begin
         wb_s.ack <= 1'b0;   // Single cycle ack
         busy     <= 1'b0;
      end else if (wb_m.cyc && wb_m.stb) begin
         if (!busy) begin
            busy      <= 1'b1;
            wait_left <= 2'($urandom_range(3, 0));   // Wait states for this cycle
         end else if (wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
         end else begin
            wb_s.ack <= 1'b1;
            if (wb_m.we) begin
               mem[word_addr(wb_m.adr)] = wb_m.dat;
            end else if (mem.exists(word_addr(wb_m.adr))) begin
               wb_s.dat <= mem[word_addr(wb_m.adr)];
            end else begin
               wb_s.dat <= ~word_addr(wb_m.adr);   // Never written
            end
            if (txn_count < LOG_DEPTH) begin
               txn_adr[txn_count] = wb_m.adr;
               txn_we[txn_count]  = wb_m.we;
               txn_dat[txn_count] = wb_m.dat;
            end
            txn_count = txn_count + 1;
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/mem_sys_sva.sv
`timescale 1ns/10ps
`default_nettype none

module mem_sys_sva
   import mem_sys_pkg::*;
(
   input logic    clk,
   input logic    mem_wb_reset,
   input wb_m2s_t wb_o,
   input wb_s2m_t wb_i
);

   int fail_count = 0;

   // Slave acks only a strobed cycle
   ack_in_cycle: assert property (@(posedge clk) disable iff (mem_wb_reset)
      wb_i.ack |-> wb_o.cyc && wb_o.stb)
      else begin
         fail_count++;
         $error("ack is high outside a bus cycle");
      end

   // Master holds its request until the slave acks
   fields_held: assert property (@(posedge clk) disable iff (mem_wb_reset)
      wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable({wb_o.adr, wb_o.we, wb_o.dat}))
      else begin
         fail_count++;
         $error("adr, we or dat changed or stb dropped before ack");
      end

   cyc_low_after_reset: assert property (@(posedge clk)
      mem_wb_reset |=> !wb_o.cyc)
      else begin
         fail_count++;
         $error("cyc is high in the cycle after reset");
      end

endmodule

`default_nettype wire

// File: tests/tb_mem_sys.sv
`timescale 1ns/10ps
`default_nettype none
`include "mem_sys_macros.svh"

module tb_mem_sys
   import mem_sys_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int IN_DELAY     = 1;
   localparam int RESET_CYCLES = 10;
   localparam int MAX_WAIT     = 40;    // Cycles allowed for one access
   localparam int N_ACCESS     = 220;   // Upper bound over all tests
   localparam int WORST_CYCLES = 16;    // Miss queued behind the other cache with full wait states

   typedef logic [`MS_DATA_W-1:0] word_t;

   logic       clk;
   logic       mem_wb_reset;
   ic_req_t    ic_req;
   dc_req_t    dc_req;
   wb_s2m_t    wb_i;
   cache_rsp_t ic_rsp;
   cache_rsp_t dc_rsp;
   wb_m2s_t    wb_o;
   int         errors;

   mem_sys_top mem_sys_top_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .ic_req       (ic_req),
      .dc_req       (dc_req),
      .wb_i         (wb_i),
      .ic_rsp       (ic_rsp),
      .dc_rsp       (dc_rsp),
      .wb_o         (wb_o)
   );

   wb_mem_model mem_model_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .wb_m         (wb_o),
      .wb_s         (wb_i)
   );

   bind mem_arbiter mem_sys_sva mem_sys_sva_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .wb_o         (wb_o),
      .wb_i         (wb_i)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // Memory contents of a word that was never written
   function automatic word_t default_word(input word_t addr);
      return ~{addr[`MS_ADDR_W-1:`MS_OFFSET_W], {`MS_OFFSET_W{1'b0}}};
   endfunction

   // Eight words on four lines with two tags per line
   function automatic word_t mix_addr(input int k);
      return 32'h0000_8000 + 32'(k % 2) * 32'h400 + 32'(k / 2) * 4;
   endfunction

   task automatic check_value(input string test, input word_t exp, input word_t act);
      assert (act === exp) else begin
         errors++;
         $display("Fail %s: expected %h, actual %h", test, exp, act);
      end
   endtask

   // Entered at posedge plus IN_DELAY with the request driven and left at the same point
   task automatic wait_hit(input string test, input bit dside, output word_t data,
                           output int waited);
      waited = 0;
      @(negedge clk);
      while (!(dside ? dc_rsp.hit : ic_rsp.hit) && waited < MAX_WAIT) begin
         @(negedge clk);
         waited++;
      end
      assert (dside ? dc_rsp.hit : ic_rsp.hit) else begin
         errors++;
         $display("%s: no hit from the %s cache within %0d cycles", test,
                  dside ? "data" : "instruction", MAX_WAIT);
      end
      data = dside ? dc_rsp.data : ic_rsp.data;
      @(posedge clk);
      #IN_DELAY;
      if (dside) begin
         dc_req = '0;
      end else begin
         ic_req = '0;
      end
   endtask

   task automatic access(input string test, input bit dside, input bit wr, input word_t addr,
                         input word_t wdata, output word_t data, output int waited);
      if (dside) begin
         dc_req = '{rd: !wr, wr: wr, addr: addr, wdata: wdata};
      end else begin
         ic_req = '{rd: 1'b1, addr: addr};   // Instruction side reads only
      end
      wait_hit(test, dside, data, waited);
   endtask

   // Runs in the last reset cycle with reads of uncached lines offered to both caches
   task automatic check_reset_state();
      ic_req = '{rd: 1'b1, addr: 32'h0000_1000};
      dc_req = '{rd: 1'b1, wr: 1'b0, addr: 32'h0000_2040, wdata: '0};
      @(negedge clk);
      check_value("reset", 0, 32'({wb_o.cyc, wb_o.stb, ic_rsp.hit, dc_rsp.hit}));
      @(posedge clk);
      #IN_DELAY;
      ic_req = '0;
      dc_req = '0;
   endtask

   task automatic icache_miss_then_hit();
      word_t addr;
      word_t data;
      int    start;
      int    waited;
      addr  = 32'h0000_1000;
      start = mem_model_i.txn_count;
      access("icache_miss", 1'b0, 1'b0, addr, '0, data, waited);
      check_value("icache_miss", default_word(addr), data);
      check_value("icache_miss", 1, mem_model_i.txn_count - start);
      check_value("icache_miss", addr, mem_model_i.txn_adr[start]);
      check_value("icache_miss", 0, 32'(mem_model_i.txn_we[start]));
      start = mem_model_i.txn_count;
      access("icache_hit", 1'b0, 1'b0, addr, '0, data, waited);
      check_value("icache_hit", default_word(addr), data);
      check_value("icache_hit", 0, waited);
      check_value("icache_hit", 0, mem_model_i.txn_count - start);
   endtask

   task automatic dcache_write_then_read();
      word_t addr;
      word_t val;
      word_t data;
      int    start;
      int    waited;
      addr  = 32'h0000_2040;
      val   = 32'hcafe_0001;
      start = mem_model_i.txn_count;
      access("dcache_write", 1'b1, 1'b1, addr, val, data, waited);
      check_value("dcache_write", 1, mem_model_i.txn_count - start);
      check_value("dcache_write", 1, 32'(mem_model_i.txn_we[start]));
      check_value("dcache_write", addr, mem_model_i.txn_adr[start]);
      check_value("dcache_write", val, mem_model_i.txn_dat[start]);
      start = mem_model_i.txn_count;
      access("dcache_read_miss", 1'b1, 1'b0, addr, '0, data, waited);
      check_value("dcache_read_miss", val, data);
      check_value("dcache_read_miss", 1, mem_model_i.txn_count - start);   // No allocate on write
      start = mem_model_i.txn_count;
      access("dcache_read_hit", 1'b1, 1'b0, addr, '0, data, waited);
      check_value("dcache_read_hit", val, data);
      check_value("dcache_read_hit", 0, waited);
      check_value("dcache_read_hit", 0, mem_model_i.txn_count - start);
      // Store to a present line updates it in place
      access("dcache_write_hit", 1'b1, 1'b1, addr, ~val, data, waited);
      access("dcache_write_hit", 1'b1, 1'b0, addr, '0, data, waited);
      check_value("dcache_write_hit", ~val, data);
      check_value("dcache_write_hit", 0, waited);
   endtask

   task automatic conflict_eviction();
      word_t first;
      word_t second;
      word_t data;
      int    start;
      int    waited;
      first  = 32'h0000_3008;
      second = first + 32'h40;   // Same index with another tag
      access("eviction", 1'b1, 1'b0, first, '0, data, waited);
      access("eviction", 1'b1, 1'b0, second, '0, data, waited);
      check_value("eviction", default_word(second), data);
      start = mem_model_i.txn_count;
      access("eviction", 1'b1, 1'b0, first, '0, data, waited);
      check_value("eviction", default_word(first), data);
      check_value("eviction", 1, mem_model_i.txn_count - start);
   endtask

   task automatic arbitration_order();
      word_t ic_addr;
      word_t dc_addr;
      word_t ic_data;
      word_t dc_data;
      int    ic_waited;
      int    dc_waited;
      int    start;
      ic_addr = 32'h0000_6010;
      dc_addr = 32'h0000_5010;
      start   = mem_model_i.txn_count;
      ic_req  = '{rd: 1'b1, addr: ic_addr};
      dc_req  = '{rd: 1'b1, wr: 1'b0, addr: dc_addr, wdata: '0};
      fork
         wait_hit("arbitration", 1'b0, ic_data, ic_waited);
         wait_hit("arbitration", 1'b1, dc_data, dc_waited);
      join
      check_value("arbitration", 2, mem_model_i.txn_count - start);
      check_value("arbitration", dc_addr, mem_model_i.txn_adr[start]);
      check_value("arbitration", ic_addr, mem_model_i.txn_adr[start + 1]);
      check_value("arbitration", default_word(ic_addr), ic_data);
      check_value("arbitration", default_word(dc_addr), dc_data);
   endtask

   task automatic random_mix();
      word_t ref_mem [8];
      word_t wdata;
      word_t data;
      int    k;
      int    waited;
      bit    wr;
      for (int i = 0; i < 8; i++) begin
         ref_mem[i] = default_word(mix_addr(i));
      end
      repeat (200) begin
         k     = $urandom_range(7, 0);
         wr    = 1'($urandom_range(1, 0));
         wdata = $urandom;
         access("random_mix", 1'b1, wr, mix_addr(k), wdata, data, waited);
         if (wr) begin
            ref_mem[k] = wdata;
         end else begin
            check_value("random_mix", ref_mem[k], data);
         end
      end
   endtask

   // Watchdog
   initial begin
      #((RESET_CYCLES + N_ACCESS * WORST_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired before the tests completed");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      int sva_fails;
      void'($urandom(32'h27e9));
      errors       = 0;
      mem_wb_reset = 1'b1;
      ic_req       = '0;
      dc_req       = '0;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      #IN_DELAY;
      check_reset_state();   // Holds reset over the tenth edge
      mem_wb_reset = 1'b0;
      icache_miss_then_hit();
      dcache_write_then_read();
      conflict_eviction();
      arbitration_order();
      random_mix();
      sva_fails = mem_sys_top_i.mem_arbiter_i.mem_sys_sva_i.fail_count;
      $display("Summary: %0d check errors, %0d assertion failures", errors, sva_fails);
      if (errors == 0 && sva_fails == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/mem_sys_pkg.sv
cache/cache_array.sv
cache/icache.sv
cache/dcache.sv
rtl/mem_arbiter.sv
rtl/mem_sys_top.sv
tests/wb_mem_model.sv
tests/mem_sys_sva.sv
tests/tb_mem_sys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_sys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
